/* design/masku_pkg.sv */
// Mask unit package
// Lane count, word and beat sizes, and the vector types shared by the
// control, the ALU and the result queue

package masku_pkg;

  // Number of lanes delivering one word each per beat
  localparam int unsigned NrLanes = 2;
  // Width of one lane word
  localparam int unsigned ElenBits = 64;
  // Bits per beat over all lanes
  localparam int unsigned BeatBits = NrLanes * ElenBits;
  // Number of instruction ids
  localparam int unsigned NrVInsn = 8;
  // Entries of the result queue
  localparam int unsigned ResultQueueDepth = 2;

  // One lane's data word
  typedef logic [ElenBits-1:0] elen_t;
  // One beat over all lanes, lane 0 in the low word
  typedef logic [BeatBits-1:0] beat_t;
  // Vector length or remaining bit count
  typedef logic [15:0] vlen_t;
  // Instruction id
  typedef logic [$clog2(NrVInsn)-1:0] vid_t;
  // Register-file word address
  typedef logic [7:0] vaddr_t;
  // One bit per instruction id
  typedef logic [NrVInsn-1:0] vinsn_mask_t;
  // One bit per lane
  typedef logic [NrLanes-1:0] lane_mask_t;

endpackage

/* design/masku_ctrl.sv */
// Mask unit control
// Holds one instruction, counts the bits still to issue and the beats
// still to retire, accepts operand beats and pulses done per id

`timescale 1ns/1ps

module masku_ctrl import masku_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  // Instruction from the sequencer
  input  logic        req_valid_i,
  input  vlen_t       req_vl_i,
  input  logic        req_vm_i,
  input  vid_t        req_id_i,
  input  vaddr_t      req_vd_i,
  output logic        req_ready_o,
  // Operand handshake with the lanes
  input  lane_mask_t  opa_valid_i,
  input  lane_mask_t  opb_valid_i,
  input  lane_mask_t  opm_valid_i,
  output lane_mask_t  opa_ready_o,
  output lane_mask_t  opb_ready_o,
  output lane_mask_t  opm_ready_o,
  // Result queue status
  input  logic        q_full_i,
  input  logic        q_retire_i,
  // Current beat towards ALU and queue
  output logic        vm_o,
  output vlen_t       issue_left_o,
  output logic        push_o,
  output vaddr_t      push_addr_o,
  output vid_t        id_o,
  output vinsn_mask_t done_o
);

  // Instruction slot
  logic   busy_q;
  logic   vm_q;
  vid_t   id_q;
  vaddr_t addr_q;
  // Bits still to issue, saturating at zero
  vlen_t  issue_left_q;
  vlen_t  issue_next;
  // Beats pushed but not yet retired
  logic [$clog2(ResultQueueDepth):0] pending_q, pending_d;
  logic        accept;
  logic        operands_ok;
  logic        push;
  logic        finish;
  vinsn_mask_t done_d;

  // Only one instruction in flight
  assign req_ready_o = !busy_q;
  assign accept      = req_valid_i && !busy_q;

  // Mask lanes only matter for masked instructions
  assign operands_ok = (&opa_valid_i) && (&opb_valid_i) && (vm_q || (&opm_valid_i));
  assign push = busy_q && (issue_left_q != '0) && operands_ok && !q_full_i;

  // Readies pulse for all lanes in the consuming cycle only
  assign opa_ready_o = {NrLanes{push}};
  assign opb_ready_o = {NrLanes{push}};
  assign opm_ready_o = {NrLanes{push && !vm_q}};

  assign vm_o         = vm_q;
  assign issue_left_o = issue_left_q;
  assign push_o       = push;
  assign push_addr_o  = addr_q;
  assign id_o         = id_q;

  // One beat covers BeatBits bits, the last one may be partial
  assign issue_next = (issue_left_q > vlen_t'(BeatBits)) ?
                      issue_left_q - vlen_t'(BeatBits) : '0;

  always_comb begin
    pending_d = pending_q;
    if (push) begin
      pending_d = pending_d + 1'b1;
    end
    if (q_retire_i) begin
      pending_d = pending_d - 1'b1;
    end
  end

  // Last beat retired and nothing left to issue
  assign finish = busy_q && q_retire_i && (issue_left_q == '0) && (pending_d == '0);

  always_comb begin
    done_d = '0;
    done_d[id_q] = finish;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q       <= 1'b0;
      issue_left_q <= '0;
      pending_q    <= '0;
      done_o       <= '0;
    end else begin
      pending_q <= pending_d;
      done_o    <= done_d;
      if (accept) begin
        busy_q       <= 1'b1;
        issue_left_q <= req_vl_i;
      end else begin
        if (push) begin
          issue_left_q <= issue_next;
        end
        // Slot is freed by the same edge that raises done
        if (finish) begin
          busy_q <= 1'b0;
        end
      end
    end
  end

  // Instruction fields and beat address
  always_ff @(posedge clk_i) begin
    if (accept) begin
      vm_q   <= req_vm_i;
      id_q   <= req_id_i;
      addr_q <= req_vd_i;
    end else if (push) begin
      addr_q <= addr_q + 1'b1;
    end
  end

endmodule

/* design/mask_alu.sv */
// Mask ALU
// Builds the bit enable of one beat from the remaining length and the
// mask, then merges the ALU result into the old destination value

`timescale 1ns/1ps

module mask_alu import masku_pkg::*; (
  input  beat_t opa_i,
  input  beat_t opb_i,
  input  beat_t opm_i,
  input  logic  vm_i,
  input  vlen_t issue_left_i,
  output beat_t result_o
);

  // Bits below the remaining vector length
  beat_t vl_en;
  // Bits allowed by the mask
  beat_t mask_en;
  // Final per-bit select
  beat_t bit_en;

  always_comb begin
    for (int i = 0; i < BeatBits; i++) begin
      vl_en[i] = vlen_t'(i) < issue_left_i;
    end
  end

  // Unmasked instructions enable every bit
  assign mask_en = vm_i ? '1 : opm_i;

  assign bit_en = vl_en & mask_en;

  // Tail and masked-off bits keep the old destination value
  assign result_o = (opa_i & bit_en) | (opb_i & ~bit_en);

endmodule

/* design/result_queue.sv */
// Result queue of the mask unit
// Small ring of beats waiting for write-back, each lane requests on its
// own and the head entry retires once every lane was granted

`timescale 1ns/1ps

module result_queue import masku_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  // Push side
  input  logic       push_i,
  input  beat_t      push_data_i,
  input  vaddr_t     push_addr_i,
  input  vid_t       push_id_i,
  output logic       full_o,
  // Write-back side
  output logic       retire_o,
  output lane_mask_t result_req_o,
  output vaddr_t     result_addr_o,
  output vid_t       result_id_o,
  output beat_t      result_wdata_o,
  input  lane_mask_t result_gnt_i
);

  // Entry payload, one word per lane
  elen_t  [ResultQueueDepth-1:0][NrLanes-1:0] wdata_q;
  vaddr_t [ResultQueueDepth-1:0] addr_q;
  vid_t   [ResultQueueDepth-1:0] id_q;
  // Lanes still requesting, per entry
  lane_mask_t [ResultQueueDepth-1:0] valid_q;

  logic [$clog2(ResultQueueDepth)-1:0] wr_ptr_q, rd_ptr_q;
  logic [$clog2(ResultQueueDepth):0]   cnt_q;

  lane_mask_t head_left;
  logic       retire;

  assign full_o = cnt_q == ($clog2(ResultQueueDepth) + 1)'(ResultQueueDepth);

  // Head entry towards the lanes
  assign result_req_o   = valid_q[rd_ptr_q];
  assign result_addr_o  = addr_q[rd_ptr_q];
  assign result_id_o    = id_q[rd_ptr_q];
  assign result_wdata_o = wdata_q[rd_ptr_q];

  // Lanes of the head still waiting after this cycle's grants
  assign head_left = valid_q[rd_ptr_q] & ~result_gnt_i;
  assign retire    = (cnt_q != '0) && (head_left == '0);
  assign retire_o  = retire;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      // Granted lanes drop their request
      valid_q[rd_ptr_q] <= head_left;
      if (retire) begin
        rd_ptr_q <= (rd_ptr_q == ResultQueueDepth - 1) ? '0 : rd_ptr_q + 1'b1;
      end
      // A push never targets a live head, so it may overwrite here
      if (push_i) begin
        valid_q[wr_ptr_q] <= '1;
        wr_ptr_q <= (wr_ptr_q == ResultQueueDepth - 1) ? '0 : wr_ptr_q + 1'b1;
      end
      if (push_i && !retire) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (!push_i && retire) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      wdata_q[wr_ptr_q] <= push_data_i;
      addr_q[wr_ptr_q]  <= push_addr_i;
      id_q[wr_ptr_q]    <= push_id_i;
    end
  end

endmodule

/* design/masku.sv */
// Mask unit top level
// Merges mask-logical ALU results into the old destination under vl and
// the mask, and writes them back to the lanes through a result queue

`timescale 1ns/1ps

module masku import masku_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  // Sequencer
  input  logic        req_valid_i,
  input  vlen_t       req_vl_i,
  input  logic        req_vm_i,
  input  vid_t        req_id_i,
  input  vaddr_t      req_vd_i,
  output logic        req_ready_o,
  // Operands from the lanes
  input  lane_mask_t  opa_valid_i,
  input  lane_mask_t  opb_valid_i,
  input  lane_mask_t  opm_valid_i,
  input  beat_t       opa_i,
  input  beat_t       opb_i,
  input  beat_t       opm_i,
  output lane_mask_t  opa_ready_o,
  output lane_mask_t  opb_ready_o,
  output lane_mask_t  opm_ready_o,
  // Write-back to the lanes
  output lane_mask_t  result_req_o,
  output vaddr_t      result_addr_o,
  output vid_t        result_id_o,
  output beat_t       result_wdata_o,
  input  lane_mask_t  result_gnt_i,
  // Completion
  output vinsn_mask_t done_o
);

  logic   q_full;
  logic   q_retire;
  logic   vm;
  vlen_t  issue_left;
  logic   push;
  vaddr_t push_addr;
  vid_t   push_id;
  beat_t  alu_result;

  masku_ctrl i_ctrl (
    .clk_i, .rst_ni,
    .req_valid_i, .req_vl_i, .req_vm_i, .req_id_i, .req_vd_i, .req_ready_o,
    .opa_valid_i, .opb_valid_i, .opm_valid_i,
    .opa_ready_o, .opb_ready_o, .opm_ready_o,
    .q_full_i     (q_full),
    .q_retire_i   (q_retire),
    .vm_o         (vm),
    .issue_left_o (issue_left),
    .push_o       (push),
    .push_addr_o  (push_addr),
    .id_o         (push_id),
    .done_o
  );

  mask_alu i_alu (
    .opa_i, .opb_i, .opm_i,
    .vm_i         (vm),
    .issue_left_i (issue_left),
    .result_o     (alu_result)
  );

  result_queue i_queue (
    .clk_i, .rst_ni,
    .push_i      (push),
    .push_data_i (alu_result),
    .push_addr_i (push_addr),
    .push_id_i   (push_id),
    .full_o      (q_full),
    .retire_o    (q_retire),
    .result_req_o, .result_addr_o, .result_id_o, .result_wdata_o, .result_gnt_i
  );

endmodule

/* tests/masku_asserts.sv */
// Protocol assertions for the mask unit
// Bound to the top level, covers done, operand readies and result requests

`timescale 1ns/1ps

module masku_asserts import masku_pkg::*; (
  input logic        clk_i,
  input logic        rst_ni,
  input lane_mask_t  opa_valid_i,
  input lane_mask_t  opb_valid_i,
  input lane_mask_t  opm_valid_i,
  input lane_mask_t  opa_ready_o,
  input lane_mask_t  opb_ready_o,
  input lane_mask_t  opm_ready_o,
  input lane_mask_t  result_req_o,
  input lane_mask_t  result_gnt_i,
  input vaddr_t      result_addr_o,
  input beat_t       result_wdata_o,
  input vinsn_mask_t done_o
);

  // At most one id completes per cycle
  done_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(done_o))
    else $error("done_o has more than one id set");

  // No ready without the matching valid
  ready_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ((opa_ready_o & ~opa_valid_i) | (opb_ready_o & ~opb_valid_i) |
     (opm_ready_o & ~opm_valid_i)) == '0)
    else $error("operand ready raised without its valid");

  // A lane request waits for its grant with address and data held
  for (genvar l = 0; l < NrLanes; l++) begin : g_lane
    req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
      result_req_o[l] && !result_gnt_i[l] |=> result_req_o[l] &&
      $stable(result_addr_o) && $stable(result_wdata_o[l*ElenBits +: ElenBits]))
      else $error("lane %0d request dropped or changed before its grant", l);
  end

endmodule

bind masku masku_asserts i_asserts (
  .clk_i, .rst_ni, .opa_valid_i, .opb_valid_i, .opm_valid_i,
  .opa_ready_o, .opb_ready_o, .opm_ready_o,
  .result_req_o, .result_gnt_i, .result_addr_o, .result_wdata_o, .done_o
);

/* tests/masku_tb.sv */
// Mask unit testbench
// Replays instructions and operand beats from a golden file, withholds and
// randomizes write-back grants, checks results, addresses and done pulses

`timescale 1ns/1ps

module masku_tb import masku_pkg::*; ();

  logic        clk_i;
  logic        rst_ni;
  logic        req_valid_i;
  vlen_t       req_vl_i;
  logic        req_vm_i;
  vid_t        req_id_i;
  vaddr_t      req_vd_i;
  logic        req_ready_o;
  lane_mask_t  opa_valid_i;
  lane_mask_t  opb_valid_i;
  lane_mask_t  opm_valid_i;
  beat_t       opa_i;
  beat_t       opb_i;
  beat_t       opm_i;
  lane_mask_t  opa_ready_o;
  lane_mask_t  opb_ready_o;
  lane_mask_t  opm_ready_o;
  lane_mask_t  result_req_o;
  vaddr_t      result_addr_o;
  vid_t        result_id_o;
  beat_t       result_wdata_o;
  lane_mask_t  result_gnt_i;
  vinsn_mask_t done_o;

  // Golden instructions and their beats
  vlen_t  insn_vl[$];
  logic   insn_vm[$];
  vid_t   insn_id[$];
  vaddr_t insn_vd[$];
  int     insn_first[$];
  int     insn_beats[$];
  beat_t  beat_a[$];
  beat_t  beat_b[$];
  beat_t  beat_m[$];
  beat_t  beat_exp[$];

  int          errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          beats_taken = 0;
  int          timeout_cycles = 200;
  logic        aborted = 1'b0;
  logic        gnt_enable = 1'b0;
  logic [15:0] lfsr_q = 16'd47124;

  masku masku_i (.*);

  initial begin
    clk_i = 1'b0;
    forever begin
      #50 clk_i = ~clk_i;
    end
  end

  // 16-bit Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    logic fb;
    fb = state[15] ^ state[13] ^ state[12] ^ state[10];
    return {state[14:0], fb};
  endfunction

  // Full-width select of the given lanes' words
  function automatic beat_t lane_select(input lane_mask_t lanes);
    beat_t sel;
    for (int l = 0; l < NrLanes; l++) begin
      sel[l*ElenBits +: ElenBits] = {ElenBits{lanes[l]}};
    end
    return sel;
  endfunction

  // Random per-lane grants, one LFSR step per lane bit
  initial begin
    lane_mask_t gnt;
    result_gnt_i = '0;
    forever begin
      @(posedge clk_i);
      #1;
      gnt = '0;
      for (int l = 0; l < NrLanes; l++) begin
        if (gnt_enable) begin
          lfsr_q = lfsr_next(lfsr_q);
          gnt[l] = lfsr_q[0];
        end
      end
      result_gnt_i = gnt;
    end
  end

  task automatic check_beat(input string name, input beat_t exp, input beat_t act);
    if (act !== exp) begin
      $display("[ERROR] %s: wdata expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_addr(input string name, input vaddr_t exp, input vaddr_t act);
    if (act !== exp) begin
      $display("[ERROR] %s: address expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_id(input string name, input vid_t exp, input vid_t act);
    if (act !== exp) begin
      $display("[ERROR] %s: result id expected %0d, actual %0d", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_done(input string name, input vinsn_mask_t exp, input vinsn_mask_t act);
    if (act !== exp) begin
      $display("[ERROR] %s: done expected %b, actual %b", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_lanes(input string name, input lane_mask_t exp, input lane_mask_t act);
    if (act !== exp) begin
      $display("[ERROR] %s: lane bits expected %b, actual %b", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[ERROR] %s: req_ready expected %b, actual %b", name, exp, act);
      errors++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timed out after %0d cycles waiting for %s", timeout_cycles, what);
    errors++;
    aborted = 1'b1;
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: %0d errors", name, errors - errors_before);
    end
  endtask

  // Lines starting with I are instructions, with B their beats
  task automatic load_golden();
    int          fd;
    int          n;
    int          last;
    string       line;
    byte         kind;
    logic [15:0] f_vl;
    logic [7:0]  f_vm;
    logic [7:0]  f_id;
    logic [7:0]  f_vd;
    beat_t       f_a;
    beat_t       f_b;
    beat_t       f_m;
    beat_t       f_exp;
    fd = $fopen("tests/masku_golden.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the golden file tests/masku_golden.txt");
      errors++;
      aborted = 1'b1;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 1 && line.getc(0) == "I") begin
        n = $sscanf(line, "%c %h %h %h %h", kind, f_vl, f_vm, f_id, f_vd);
        insn_vl.push_back(f_vl);
        insn_vm.push_back(f_vm[0]);
        insn_id.push_back(vid_t'(f_id));
        insn_vd.push_back(f_vd);
        insn_first.push_back(beat_a.size());
      end else if (n > 1 && line.getc(0) == "B") begin
        n = $sscanf(line, "%c %h %h %h %h", kind, f_a, f_b, f_m, f_exp);
        beat_a.push_back(f_a);
        beat_b.push_back(f_b);
        beat_m.push_back(f_m);
        beat_exp.push_back(f_exp);
      end
    end
    $fclose(fd);
    for (int i = 0; i < insn_first.size(); i++) begin
      last = (i + 1 < insn_first.size()) ? insn_first[i+1] : beat_a.size();
      insn_beats.push_back(last - insn_first[i]);
    end
  endtask

  task automatic issue_insn(input int idx);
    int cycles;
    req_valid_i = 1'b1;
    req_vl_i    = insn_vl[idx];
    req_vm_i    = insn_vm[idx];
    req_id_i    = insn_id[idx];
    req_vd_i    = insn_vd[idx];
    cycles = 0;
    @(negedge clk_i);
    while (!req_ready_o && cycles < timeout_cycles) begin
      @(negedge clk_i);
      cycles++;
    end
    if (!req_ready_o) begin
      report_timeout("the instruction handshake");
    end
    @(posedge clk_i);
    #1;
    req_valid_i = 1'b0;
  endtask

  task automatic drive_beats(input int idx, input string name);
    int         cycles;
    int         b;
    lane_mask_t exp_m;
    exp_m = insn_vm[idx] ? '0 : '1;
    for (int k = 0; k < insn_beats[idx] && !aborted; k++) begin
      b = insn_first[idx] + k;
      opa_i = beat_a[b];
      opb_i = beat_b[b];
      opm_i = beat_m[b];
      opa_valid_i = '1;
      opb_valid_i = '1;
      // Unmasked instructions must not need the mask lanes
      opm_valid_i = exp_m;
      cycles = 0;
      @(negedge clk_i);
      while (opa_ready_o != '1 && cycles < timeout_cycles) begin
        @(negedge clk_i);
        cycles++;
      end
      if (opa_ready_o != '1) begin
        report_timeout("an operand handshake");
      end else begin
        beats_taken++;
        check_lanes(name, '1, opb_ready_o);
        check_lanes(name, exp_m, opm_ready_o);
      end
      @(posedge clk_i);
      #1;
    end
    opa_valid_i = '0;
    opb_valid_i = '0;
    opm_valid_i = '0;
  endtask

  // Follows the head entry lane by lane, beat k goes to vd + k
  task automatic collect_results(input int idx, input string name);
    int         k;
    int         cycles;
    lane_mask_t granted;
    lane_mask_t written;
    beat_t      sel;
    k = 0;
    cycles = 0;
    written = '0;
    while (k < insn_beats[idx] && !aborted) begin
      @(negedge clk_i);
      check_done(name, '0, done_o);
      granted = result_req_o & result_gnt_i;
      if (granted != '0) begin
        sel = lane_select(granted);
        check_beat(name, beat_exp[insn_first[idx] + k] & sel, result_wdata_o & sel);
        check_addr(name, insn_vd[idx] + vaddr_t'(k), result_addr_o);
        check_id(name, insn_id[idx], result_id_o);
        written = written | granted;
        cycles = 0;
        if (written == '1) begin
          k++;
          written = '0;
        end
      end else if (cycles >= timeout_cycles) begin
        report_timeout("the write-back of a beat");
      end else begin
        cycles++;
      end
    end
  endtask

  // Grants withheld, so two beats fill the queue and the third waits
  task automatic watch_stall(input string name);
    int cycles;
    cycles = 0;
    while (beats_taken < 2 && cycles < timeout_cycles && !aborted) begin
      @(negedge clk_i);
      cycles++;
    end
    if (beats_taken < 2) begin
      report_timeout("the first two operand beats");
    end else begin
      repeat (8) begin
        @(negedge clk_i);
        check_lanes(name, '0, opa_ready_o);
        check_lanes(name, '1, result_req_o);
      end
      if (beats_taken != 2) begin
        $display("%s: more than two beats were accepted with grants withheld", name);
        errors++;
      end
    end
    gnt_enable = 1'b1;
  endtask

  task automatic run_insn(input int idx);
    string       name;
    int          need;
    int          errors_before;
    vinsn_mask_t onehot;
    name = $sformatf("insn %0d (id %0d, vl %0d)", idx, insn_id[idx], insn_vl[idx]);
    errors_before = errors;
    need = (int'(insn_vl[idx]) + BeatBits - 1) / BeatBits;
    if (need != insn_beats[idx]) begin
      $display("%s: golden file gives %0d beats but vl needs %0d", name, insn_beats[idx], need);
      errors++;
    end else begin
      gnt_enable = (need < 3);
      beats_taken = 0;
      @(posedge clk_i);
      #1;
      issue_insn(idx);
      fork
        drive_beats(idx, name);
        collect_results(idx, name);
        if (need >= 3) watch_stall(name);
      join
      if (!aborted) begin
        onehot = '0;
        onehot[insn_id[idx]] = 1'b1;
        // Done one cycle after the last retirement, for one cycle
        @(negedge clk_i);
        check_done(name, onehot, done_o);
        @(negedge clk_i);
        check_done(name, '0, done_o);
        check_flag(name, 1'b1, req_ready_o);
      end
    end
    report_test(name, errors_before);
  endtask

  initial begin
    int errors_before;
    rst_ni      = 1'b0;
    req_valid_i = 1'b0;
    req_vl_i    = '0;
    req_vm_i    = 1'b0;
    req_id_i    = '0;
    req_vd_i    = '0;
    opa_valid_i = '0;
    opb_valid_i = '0;
    opm_valid_i = '0;
    opa_i       = '0;
    opb_i       = '0;
    opm_i       = '0;
    repeat (2) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    load_golden();
    if (!aborted && insn_vl.size() == 0) begin
      $display("The golden file holds no instructions");
      errors++;
    end
    errors_before = errors;
    @(negedge clk_i);
    check_flag("reset", 1'b1, req_ready_o);
    check_lanes("reset", '0, opa_ready_o);
    check_lanes("reset", '0, opb_ready_o);
    check_lanes("reset", '0, opm_ready_o);
    check_lanes("reset", '0, result_req_o);
    check_done("reset", '0, done_o);
    report_test("reset", errors_before);
    for (int i = 0; i < insn_vl.size() && !aborted; i++) begin
      run_insn(i);
    end
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* tests/masku_golden.txt */
// I vl vm id vd : instruction, all hex
// B a b m expected_wdata : one 128-bit beat, lane 0 in the low word
I 0080 1 7 10
B 0123456789abcdeffedcba9876543210 ffffffffffffffffffffffffffffffff 00000000000000000000000000000000 0123456789abcdeffedcba9876543210
I 0064 1 2 20
B aaaaaaaaaaaaaaaaaaaaaaaaaaaaaaaa 55555555555555555555555555555555 00000000000000000000000000000000 5555555aaaaaaaaaaaaaaaaaaaaaaaaa
I 0080 0 3 30
B ffffffffffffffffffffffffffffffff 00000000000000000000000000000000 0123456789abcdeffedcba9876543210 0123456789abcdeffedcba9876543210
I 012c 0 4 40
B ffffffffffffffffffffffffffffffff 00000000000000000000000000000000 ffff0000ffff0000ffff0000ffff0000 ffff0000ffff0000ffff0000ffff0000
B 00000000000000000000000000000000 ffffffffffffffffffffffffffffffff 00ff00ff00ff00ff00ff00ff00ff00ff ff00ff00ff00ff00ff00ff00ff00ff00
B ffffffffffffffffffffffffffffffff 88888888888888888888888888888888 33333333333333333333333333333333 888888888888888888888bbbbbbbbbbb
I 0180 1 5 50
B 11111111111111111111111111111111 ffffffffffffffffffffffffffffffff 00000000000000000000000000000000 11111111111111111111111111111111
B 22222222222222222222222222222222 ffffffffffffffffffffffffffffffff 00000000000000000000000000000000 22222222222222222222222222222222
B 33333333333333333333333333333333 ffffffffffffffffffffffffffffffff 00000000000000000000000000000000 33333333333333333333333333333333

/* build.f */
design/masku_pkg.sv
design/masku_ctrl.sv
design/mask_alu.sv
design/result_queue.sv
design/masku.sv
tests/masku_asserts.sv
tests/masku_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the mask unit testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module masku_tb -f build.f \
  -o masku_sim \
  && ./obj_dir/masku_sim | tee /dev/stderr | grep -x "test passed" > /dev/null \
  && echo "Simulation PASS" \
  || { echo "Simulation FAIL"; exit 1; }
